// ==== logic/branch_unit.sv ====
// Branch resolution in decode; taken does not wait for a load-use stall to clear
`timescale 1ns/1ps

module branch_unit (
    input  decode_pkg::branch_kind_e branch_kind,
    input  logic                     ds_valid,
    input  decode_pkg::word_t        pc,
    input  decode_pkg::word_t        rs1_value,
    input  decode_pkg::word_t        rs2_value,
    input  decode_pkg::word_t        imm,
    output decode_pkg::br_bus_t      br_bus
);
    import decode_pkg::*;

    logic  eq;
    logic  lt;
    logic  ltu;
    logic  cond;
    word_t base;

    // ------------------------------
    // Compare
    // ------------------------------
    assign eq  = (rs1_value == rs2_value);
    assign lt  = ($signed(rs1_value) < $signed(rs2_value));
    assign ltu = (rs1_value < rs2_value);

    always_comb begin
        case (branch_kind)
            br_beq:          cond = eq;
            br_bne:          cond = !eq;
            br_blt:          cond = lt;
            br_bge:          cond = !lt;
            br_bltu:         cond = ltu;
            br_bgeu:         cond = !ltu;
            br_jal, br_jalr: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    // ------------------------------
    // Target
    // ------------------------------
    // jalr keeps bit 0 as computed
    assign base = (branch_kind == br_jalr) ? rs1_value : pc;

    assign br_bus.taken  = ds_valid && cond;
    assign br_bus.target = base + imm;

endmodule

// ==== logic/decode_pkg.sv ====
// RV64I base integer only (no M extension, no W ops) and all widths fixed by the ISA
package decode_pkg;

    parameter int xlen = 64;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;

    // ------------------------------
    // Control encodings
    // ------------------------------
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic [1:0] {src_a_rs1, src_a_pc, src_a_zero} src_a_e;
    typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} src_b_e;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {mem_byte, mem_half, mem_word, mem_double} mem_size_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jal,
        br_jalr
    } branch_kind_e;

    // ------------------------------
    // Stage buses
    // ------------------------------
    typedef struct packed {
        inst_t inst;
        word_t pc;
    } fetch_bus_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_bus_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } fwd_bus_t;

    typedef struct packed {
        logic     is_load;
        fwd_bus_t fwd;
    } es_fwd_bus_t;

    typedef struct packed {
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        logic      rf_we;
        logic      mem_we;
        logic      mem_re;
        mem_size_e mem_size;
        logic      res_zext;
        reg_addr_t rd;
    } ctrl_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_bus_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t imm;
        word_t rs1_value;
        word_t rs2_value;
        word_t pc;
    } ds_to_es_bus_t;

endpackage

// ==== logic/decode_stage.sv ====
// Decode stage top; branches resolve here, and a load in execute stalls a dependent instruction
`timescale 1ns/1ps

module decode_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fs_to_ds_valid,
    input  decode_pkg::fetch_bus_t     fs_to_ds_bus,
    output logic                       ds_allowin,
    input  logic                       es_allowin,
    output logic                       ds_to_es_valid,
    output decode_pkg::ds_to_es_bus_t  ds_to_es_bus,
    input  decode_pkg::wb_bus_t        ws_to_rf_bus,
    input  decode_pkg::es_fwd_bus_t    es_fwd_bus,
    input  decode_pkg::fwd_bus_t       ms_fwd_bus,
    input  decode_pkg::fwd_bus_t       ws_fwd_bus,
    output decode_pkg::br_bus_t        br_bus,
    output logic                       stop
);
    import decode_pkg::*;

    logic         ds_valid;
    logic         ready_go;
    fetch_bus_t   held_bus;
    ctrl_t        ctrl;
    word_t        imm;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    branch_kind_e branch_kind;
    word_t        rf_data1;
    word_t        rf_data2;
    word_t        rs1_value;
    word_t        rs2_value;

    stage_reg u_stage_reg (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (fs_to_ds_valid),
        .in_bus      (fs_to_ds_bus),
        .ready_go    (ready_go),
        .out_allowin (es_allowin),
        .allowin     (ds_allowin),
        .out_valid   (ds_to_es_valid),
        .ds_valid    (ds_valid),
        .held_bus    (held_bus)
    );

    inst_decoder u_inst_decoder (
        .inst        (held_bus.inst),
        .ds_valid    (ds_valid),
        .ctrl        (ctrl),
        .imm         (imm),
        .rs1         (rs1),
        .rs2         (rs2),
        .branch_kind (branch_kind),
        .stop        (stop)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2),
        .wb     (ws_to_rf_bus)
    );

    operand_forward u_operand_forward (
        .rs1       (rs1),
        .rs2       (rs2),
        .rf_data1  (rf_data1),
        .rf_data2  (rf_data2),
        .es_fwd    (es_fwd_bus),
        .ms_fwd    (ms_fwd_bus),
        .ws_fwd    (ws_fwd_bus),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .ready_go  (ready_go)
    );

    branch_unit u_branch_unit (
        .branch_kind (branch_kind),
        .ds_valid    (ds_valid),
        .pc          (held_bus.pc),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .imm         (imm),
        .br_bus      (br_bus)
    );

    assign ds_to_es_bus = '{
        ctrl:      ctrl,
        imm:       imm,
        rs1_value: rs1_value,
        rs2_value: rs2_value,
        pc:        held_bus.pc
    };

endmodule

// ==== logic/inst_decoder.sv ====
// RV64I non-word decode only; anything else, W ops and M ops included, raises stop when valid
`timescale 1ns/1ps

module inst_decoder (
    input  logic                     ds_valid,
    input  decode_pkg::inst_t        inst,
    output decode_pkg::ctrl_t        ctrl,
    output decode_pkg::word_t        imm,
    output decode_pkg::reg_addr_t    rs1,
    output decode_pkg::reg_addr_t    rs2,
    output decode_pkg::branch_kind_e branch_kind,
    output logic                     stop
);
    import decode_pkg::*;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    logic       ebreak;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      shamt;

    // Shared by op-imm and op-reg; alt picks sub or sra
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign ebreak = (inst == 32'h0010_0073);

    // ------------------------------
    // Sign-extended immediates
    // ------------------------------
    assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign shamt = {{(xlen-6){1'b0}}, inst[25:20]};

    always_comb begin
        ctrl.alu_op   = alu_add;
        ctrl.src_a    = src_a_rs1;
        ctrl.src_b    = src_b_rs2;
        ctrl.rf_we    = 1'b0;
        ctrl.mem_we   = 1'b0;
        ctrl.mem_re   = 1'b0;
        ctrl.mem_size = mem_double;
        ctrl.res_zext = 1'b0;
        ctrl.rd       = inst[11:7];
        imm           = '0;
        branch_kind   = br_none;
        legal         = 1'b0;
        case (opcode)
            op_lui, op_auipc: begin
                legal      = 1'b1;
                ctrl.rf_we = 1'b1;
                ctrl.src_a = (opcode == op_lui) ? src_a_zero : src_a_pc;
                ctrl.src_b = src_b_imm;
                imm        = imm_u;
            end
            op_jal, op_jalr: begin
                legal       = (opcode == op_jal) || (funct3 == 3'b000);
                ctrl.rf_we  = 1'b1;
                ctrl.src_a  = src_a_pc;
                ctrl.src_b  = src_b_four;
                imm         = (opcode == op_jal) ? imm_j : imm_i;
                branch_kind = (opcode == op_jal) ? br_jal : br_jalr;
            end
            op_branch: begin
                legal = (funct3[2:1] != 2'b01);
                imm   = imm_b;
                case (funct3)
                    3'b000:  branch_kind = br_beq;
                    3'b001:  branch_kind = br_bne;
                    3'b100:  branch_kind = br_blt;
                    3'b101:  branch_kind = br_bge;
                    3'b110:  branch_kind = br_bltu;
                    3'b111:  branch_kind = br_bgeu;
                    default: branch_kind = br_none;
                endcase
            end
            op_load: begin
                legal         = (funct3 != 3'b111);
                ctrl.rf_we    = 1'b1;
                ctrl.mem_re   = 1'b1;
                ctrl.src_b    = src_b_imm;
                ctrl.mem_size = mem_size_e'(funct3[1:0]);
                ctrl.res_zext = funct3[2];
                imm           = imm_i;
            end
            op_store: begin
                legal         = !funct3[2];
                ctrl.mem_we   = 1'b1;
                ctrl.src_b    = src_b_imm;
                ctrl.mem_size = mem_size_e'(funct3[1:0]);
                imm           = imm_s;
            end
            op_imm: begin
                // 6-bit shamt, so only funct6 is checked on shifts
                case (funct3)
                    3'b001:  legal = (inst[31:26] == 6'b000000);
                    3'b101:  legal = (inst[31:26] == 6'b000000) || (inst[31:26] == 6'b010000);
                    default: legal = 1'b1;
                endcase
                ctrl.rf_we  = 1'b1;
                ctrl.src_b  = src_b_imm;
                ctrl.alu_op = alu_from_funct3(funct3, (funct3 == 3'b101) && inst[30]);
                imm         = (funct3[1:0] == 2'b01) ? shamt : imm_i;
            end
            op_reg: begin
                legal       = (funct7 == 7'b0000000) ||
                              ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
                ctrl.rf_we  = 1'b1;
                ctrl.alu_op = alu_from_funct3(funct3, inst[30]);
            end
            op_system: legal = ebreak;
            default:   legal = 1'b0;
        endcase
        // Unrecognized words leave no side effects downstream
        if (!legal) begin
            ctrl.rf_we  = 1'b0;
            ctrl.mem_we = 1'b0;
            ctrl.mem_re = 1'b0;
            branch_kind = br_none;
        end
    end

    assign stop = ds_valid && (ebreak || !legal);

endmodule

// ==== logic/operand_forward.sv ====
// Forwarding priority is execute, memory, writeback, then the register file; x0 never forwarded
`timescale 1ns/1ps

module operand_forward (
    input  decode_pkg::reg_addr_t   rs1,
    input  decode_pkg::reg_addr_t   rs2,
    input  decode_pkg::word_t       rf_data1,
    input  decode_pkg::word_t       rf_data2,
    input  decode_pkg::es_fwd_bus_t es_fwd,
    input  decode_pkg::fwd_bus_t    ms_fwd,
    input  decode_pkg::fwd_bus_t    ws_fwd,
    output decode_pkg::word_t       rs1_value,
    output decode_pkg::word_t       rs2_value,
    output logic                    ready_go
);
    import decode_pkg::*;

    logic es_hit1;
    logic es_hit2;
    logic ms_hit1;
    logic ms_hit2;
    logic ws_hit1;
    logic ws_hit2;

    // Index zero never matches, so dest of x0 is ignored too
    function automatic logic hit(input fwd_bus_t bus, input reg_addr_t idx);
        return bus.valid && (bus.dest == idx) && (idx != '0);
    endfunction

    assign es_hit1 = hit(es_fwd.fwd, rs1);
    assign es_hit2 = hit(es_fwd.fwd, rs2);
    assign ms_hit1 = hit(ms_fwd, rs1);
    assign ms_hit2 = hit(ms_fwd, rs2);
    assign ws_hit1 = hit(ws_fwd, rs1);
    assign ws_hit2 = hit(ws_fwd, rs2);

    assign rs1_value = es_hit1 ? es_fwd.fwd.data :
                       ms_hit1 ? ms_fwd.data :
                       ws_hit1 ? ws_fwd.data :
                                 rf_data1;

    assign rs2_value = es_hit2 ? es_fwd.fwd.data :
                       ms_hit2 ? ms_fwd.data :
                       ws_hit2 ? ws_fwd.data :
                                 rf_data2;

    // Load data not ready in execute yet
    assign ready_go = !(es_fwd.is_load && (es_hit1 || es_hit2));

endmodule

// ==== logic/reg_file.sv ====
// 32 x 64 registers, write lands at the edge and reads see it one cycle later (no bypass)
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2,
    input  decode_pkg::wb_bus_t   wb
);

    decode_pkg::word_t regs [0:31];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wb.we && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // Unknown index would corrupt an unknown register
    write_addr_known: assert property (
        @(posedge clk) wb.we |-> !$isunknown(wb.addr)
    ) else $error("register write with unknown address");

endmodule

// ==== logic/stage_reg.sv ====
// Holds one instruction; a new one is taken only when the stage is empty or passes its own on
`timescale 1ns/1ps

module stage_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  decode_pkg::fetch_bus_t in_bus,
    input  logic                   ready_go,
    input  logic                   out_allowin,
    output logic                   allowin,
    output logic                   out_valid,
    output logic                   ds_valid,
    output decode_pkg::fetch_bus_t held_bus
);
    import decode_pkg::*;

    assign allowin   = !ds_valid || (ready_go && out_allowin);
    assign out_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (allowin) begin
            ds_valid <= in_valid;
        end
    end

    // Payload captured on transfer only
    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            held_bus <= in_bus;
        end
    end

    held_stable: assert property (
        @(posedge clk) disable iff (reset)
        (ds_valid && !allowin) |=> $stable(held_bus)
    ) else $error("held instruction changed while stalled");

endmodule

// ==== src.f ====
+incdir+verification
logic/decode_pkg.sv
logic/stage_reg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/branch_unit.sv
logic/decode_stage.sv
verification/decode_tb.sv

// ==== verification/decode_model.svh ====
// Reference model; must be included in the testbench after the DUT input signals are declared
`ifndef decode_model_svh
`define decode_model_svh

    localparam inst_t ebreak_word = 32'h0010_0073;

    word_t      m_regs [32];
    logic       m_valid;
    fetch_bus_t m_bus;
    int         delivered = 0;
    int         stalls = 0;

    function automatic word_t sext(input word_t v, input int bits);
        return word_t'($signed(v << (xlen - bits)) >>> (xlen - bits));
    endfunction

    // ------------------------------
    // ISA decode table
    // ------------------------------
    function automatic void ref_decode(input inst_t i, output ctrl_t c, output word_t imm,
                                       output branch_kind_e bk, output logic legal);
        alu_op_e      alu_tab [8];
        branch_kind_e br_tab [8];
        logic [2:0]   f3;
        alu_tab = '{alu_add, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_or, alu_and};
        br_tab  = '{br_beq, br_bne, br_none, br_none, br_blt, br_bge, br_bltu, br_bgeu};
        f3      = i[14:12];
        c = '{alu_op: alu_add, src_a: src_a_rs1, src_b: src_b_rs2, rf_we: 1'b0, mem_we: 1'b0,
              mem_re: 1'b0, mem_size: mem_double, res_zext: 1'b0, rd: i[11:7]};
        imm   = '0;
        bk    = br_none;
        legal = 1'b1;
        case (i[6:0])
            7'b0110111, 7'b0010111: begin
                c.rf_we = 1'b1;
                c.src_a = i[5] ? src_a_zero : src_a_pc;
                c.src_b = src_b_imm;
                imm     = sext({i[31:12], 12'b0}, 32);
            end
            7'b1101111, 7'b1100111: begin
                legal   = i[3] || (f3 == 3'b000);
                c.rf_we = 1'b1;
                c.src_a = src_a_pc;
                c.src_b = src_b_four;
                imm     = i[3] ? sext({i[31], i[19:12], i[20], i[30:21], 1'b0}, 21)
                               : sext(i[31:20], 12);
                bk      = i[3] ? br_jal : br_jalr;
            end
            7'b1100011: begin
                legal = (f3 != 3'b010) && (f3 != 3'b011);
                imm   = sext({i[31], i[7], i[30:25], i[11:8], 1'b0}, 13);
                bk    = br_tab[f3];
            end
            7'b0000011, 7'b0100011: begin
                legal      = i[5] ? !f3[2] : (f3 != 3'b111);
                c.rf_we    = !i[5];
                c.mem_re   = !i[5];
                c.mem_we   = i[5];
                c.src_b    = src_b_imm;
                c.mem_size = mem_size_e'(f3[1:0]);
                c.res_zext = !i[5] && f3[2];
                imm        = i[5] ? sext({i[31:25], i[11:7]}, 12) : sext(i[31:20], 12);
            end
            7'b0010011: begin
                c.rf_we  = 1'b1;
                c.src_b  = src_b_imm;
                c.alu_op = alu_tab[f3];
                imm      = sext(i[31:20], 12);
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    legal = (i[31:26] == 6'b0) || (f3 == 3'b101 && i[31:26] == 6'b010000);
                    imm   = word_t'(i[25:20]);
                    if (i[30]) begin
                        c.alu_op = alu_sra;
                    end
                end
            end
            7'b0110011: begin
                c.rf_we  = 1'b1;
                c.alu_op = alu_tab[f3];
                legal    = (i[31:25] == 7'b0);
                if (i[31:25] == 7'b0100000) begin
                    legal    = (f3 == 3'b000) || (f3 == 3'b101);
                    c.alu_op = (f3 == 3'b000) ? alu_sub : alu_sra;
                end
            end
            7'b1110011: legal = (i == ebreak_word);
            default:    legal = 1'b0;
        endcase
        if (!legal) begin
            bk = br_none;
        end
    endfunction

    // ------------------------------
    // Operands, hazard, branches
    // ------------------------------
    function automatic word_t ref_operand(input reg_addr_t idx);
        if (idx == '0) return '0;
        if (es_fwd_bus.fwd.valid && es_fwd_bus.fwd.dest == idx) return es_fwd_bus.fwd.data;
        if (ms_fwd_bus.valid && ms_fwd_bus.dest == idx) return ms_fwd_bus.data;
        if (ws_fwd_bus.valid && ws_fwd_bus.dest == idx) return ws_fwd_bus.data;
        return m_regs[idx];
    endfunction

    function automatic logic ref_ready();
        reg_addr_t d;
        d = es_fwd_bus.fwd.dest;
        return !(es_fwd_bus.is_load && es_fwd_bus.fwd.valid && d != '0 &&
                 (d == m_bus.inst[19:15] || d == m_bus.inst[24:20]));
    endfunction

    function automatic void ref_branch(input branch_kind_e bk, input word_t a, input word_t b,
                                       input word_t pc, input word_t imm,
                                       output logic cond, output word_t target);
        case (bk)
            br_beq:          cond = (a == b);
            br_bne:          cond = (a != b);
            br_blt:          cond = ($signed(a) < $signed(b));
            br_bge:          cond = ($signed(a) >= $signed(b));
            br_bltu:         cond = (a < b);
            br_bgeu:         cond = (a >= b);
            br_jal, br_jalr: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
        target = ((bk == br_jalr) ? a : pc) + imm;
    endfunction

    // Advance one clock edge with the inputs the DUT samples at that edge
    task automatic model_step();
        logic go;
        if (reset) begin
            m_valid = 1'b0;
        end else begin
            if (ws_to_rf_bus.we && ws_to_rf_bus.addr != '0) begin
                m_regs[ws_to_rf_bus.addr] = ws_to_rf_bus.data;
            end
            go = ref_ready() && es_allowin;
            if (m_valid && !ref_ready()) begin
                stalls++;
            end
            if (m_valid && go) begin
                delivered++;
            end
            if (!m_valid || go) begin
                m_valid = fs_to_ds_valid;
                if (fs_to_ds_valid) begin
                    m_bus = fs_to_ds_bus;
                end
            end
        end
    endtask

`endif

// ==== verification/decode_tb.sv ====
// Fixed-seed random RV64I stream; inputs change at the rising edge, outputs checked at falling edge
`timescale 1ns/1ps

module decode_tb;
    import decode_pkg::*;

    localparam int reset_cycles = 8;
    localparam int num_cycles   = 4000;
    localparam int total_cycles = reset_cycles + 32 + num_cycles;

    logic          clk;
    logic          reset;
    logic          fs_to_ds_valid;
    fetch_bus_t    fs_to_ds_bus;
    logic          ds_allowin;
    logic          es_allowin;
    logic          ds_to_es_valid;
    ds_to_es_bus_t ds_to_es_bus;
    wb_bus_t       ws_to_rf_bus;
    es_fwd_bus_t   es_fwd_bus;
    fwd_bus_t      ms_fwd_bus;
    fwd_bus_t      ws_fwd_bus;
    br_bus_t       br_bus;
    logic          stop;
    int            taken_cnt = 0;
    bit            model_live = 1'b0;

    `include "decode_model.svh"

    decode_stage dut (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ws_to_rf_bus   (ws_to_rf_bus),
        .es_fwd_bus     (es_fwd_bus),
        .ms_fwd_bus     (ms_fwd_bus),
        .ws_fwd_bus     (ws_fwd_bus),
        .br_bus         (br_bus),
        .stop           (stop)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic expect_equal(input logic [127:0] got, input logic [127:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    // Small values and near-all-ones make equal and signed/unsigned compares likely
    function automatic word_t rand_data();
        case ($urandom_range(0, 3))
            0:       return word_t'($urandom_range(0, 3));
            1:       return '1 - word_t'($urandom_range(0, 3));
            default: return {$urandom, $urandom};
        endcase
    endfunction

    function automatic fwd_bus_t rand_fwd();
        fwd_bus_t f;
        f.valid = ($urandom_range(0, 2) == 0);
        f.dest  = reg_addr_t'($urandom_range(0, 7));
        f.data  = rand_data();
        return f;
    endfunction

    function automatic inst_t rand_inst();
        inst_t      w;
        logic [2:0] f3;
        w        = $urandom;
        w[19:15] = reg_addr_t'($urandom_range(0, 7));
        w[24:20] = reg_addr_t'($urandom_range(0, 7));
        f3       = w[14:12];
        case ($urandom_range(0, 12))
            0: w[6:0] = 7'b0110111;
            1: w[6:0] = 7'b0010111;
            2: w[6:0] = 7'b1101111;
            3: w = {w[31:15], 3'b000, w[11:7], 7'b1100111};
            4: begin
                w[6:0] = 7'b1100011;
                if (f3[2:1] == 2'b01) begin
                    w[13] = 1'b0;
                end
            end
            5: begin
                w[6:0] = 7'b0000011;
                if (f3 == 3'b111) begin
                    w[14] = 1'b0;
                end
            end
            6: w = {w[31:15], 1'b0, w[13:7], 7'b0100011};
            7, 8: begin
                w[6:0] = 7'b0010011;
                if (f3 == 3'b001) begin
                    w[31:26] = 6'b000000;
                end
                if (f3 == 3'b101) begin
                    w[31:26] = {1'b0, w[30], 4'b0000};
                end
            end
            9, 10: begin
                w[6:0]   = 7'b0110011;
                w[31:25] = (w[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
            end
            11:      w = ebreak_word;
            default: w = $urandom;
        endcase
        return w;
    endfunction

    task automatic drive_random();
        fs_to_ds_valid <= ($urandom_range(0, 3) != 0);
        fs_to_ds_bus   <= '{inst: rand_inst(), pc: {$urandom, $urandom} & ~64'h3};
        es_allowin     <= ($urandom_range(0, 3) != 0);
        ws_to_rf_bus   <= '{we: 1'($urandom_range(0, 1)), addr: reg_addr_t'($urandom_range(0, 7)),
                            data: rand_data()};
        es_fwd_bus     <= '{is_load: 1'($urandom_range(0, 1)), fwd: rand_fwd()};
        ms_fwd_bus     <= rand_fwd();
        ws_fwd_bus     <= rand_fwd();
    endtask

    // ------------------------------
    // Model and checks
    // ------------------------------
    always @(posedge clk) begin
        model_step();
        model_live = 1'b1;
    end

    task automatic check_outputs();
        ctrl_t        c;
        word_t        imm;
        word_t        a;
        word_t        b;
        word_t        target;
        branch_kind_e bk;
        logic         legal;
        logic         cond;
        logic         rg;
        rg = ref_ready();
        expect_equal(ds_allowin, !m_valid || (rg && es_allowin), "ds_allowin");
        expect_equal(ds_to_es_valid, m_valid && rg, "ds_to_es_valid");
        if (!m_valid) begin
            expect_equal(stop, 1'b0, "stop with empty stage");
            expect_equal(br_bus.taken, 1'b0, "taken with empty stage");
        end else begin
            ref_decode(m_bus.inst, c, imm, bk, legal);
            a = ref_operand(m_bus.inst[19:15]);
            b = ref_operand(m_bus.inst[24:20]);
            ref_branch(bk, a, b, m_bus.pc, imm, cond, target);
            expect_equal(stop, !legal || (m_bus.inst == ebreak_word), "stop");
            expect_equal(ds_to_es_bus.pc, m_bus.pc, "pc");
            expect_equal(ds_to_es_bus.rs1_value, a, "rs1_value");
            expect_equal(ds_to_es_bus.rs2_value, b, "rs2_value");
            expect_equal(br_bus.taken, cond, "br_bus.taken");
            if (legal) begin
                expect_equal(ds_to_es_bus.ctrl, c, "ctrl");
                expect_equal(ds_to_es_bus.imm, imm, "imm");
                if (bk != br_none) begin
                    expect_equal(br_bus.target, target, "br_bus.target");
                end
            end else begin
                expect_equal({ds_to_es_bus.ctrl.rf_we, ds_to_es_bus.ctrl.mem_we,
                              ds_to_es_bus.ctrl.mem_re}, 3'b000, "unrecognized side effects");
            end
            if (cond) begin
                taken_cnt++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (model_live) begin
            check_outputs();
        end
    end

    // ------------------------------
    // Sequence and verdict
    // ------------------------------
    initial begin
        void'($urandom(6755));
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        ws_to_rf_bus   = '0;
        es_fwd_bus     = '0;
        ms_fwd_bus     = '0;
        ws_fwd_bus     = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        // Fill every register so later reads are known
        for (int r = 1; r < 32; r++) begin
            ws_to_rf_bus <= '{we: 1'b1, addr: reg_addr_t'(r), data: rand_data()};
            @(posedge clk);
        end
        for (int n = 0; n < num_cycles; n++) begin
            drive_random();
            @(posedge clk);
        end
        if (delivered < num_cycles / 4 || stalls == 0 || taken_cnt == 0) begin
            $display("Too little activity: %0d delivered, %0d stall cycles, %0d taken cycles",
                     delivered, stalls, taken_cnt);
            $display("RESULT: FAIL");
            $fatal(1, "activity too low");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    initial begin
        #(20 * total_cycles);
        $display("Timeout: the stimulus sequence did not finish in time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
